//--- tests/frontend_stim.txt
# M addr word      memory image
# R cycle target   redirect in that cycle after reset
# S cycle length   back end held stalled
# D cycles         response delay ceiling
D 4
M 1c000000 04001234
M 1c000004 08000c41
M 1c000008 0c002d6b
M 1c00000c 100018a5
M 1c000010 5400abcd
M 1c000014 fc00ffff
M 1c000018 0800294a
M 1c00001c 0c0039ce
M 1c000020 10007c1f
M 1c000024 54000000
M 1c000100 fc0003e0
M 1c000104 0c001c22
M 1c000108 10001443
M 1c00010c 5400ffff
M 1c000200 08000fe0
M 1c000204 0c00fc1f
M 1c00030c 04007fff
M 1c000310 0c0073bd
R 60 1c000104
R 140 1c000200
S 220 80
R 360 1c00030c
R 440 1c000014

//--- vlog.f
hw/frontend_pkg.sv
hw/fetch_if.sv
hw/pc_gen.sv
hw/fetch_unit.sv
hw/multi_channel_fifo.sv
hw/inst_decoder.sv
hw/frontend.sv
tests/tb_clock.sv
tests/frontend_tb.sv

//--- tests/frontend_tb.sv
module frontend_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int RUN_CYCLES = 560;
    localparam int IDLE_LIMIT = 100;
    // cycles of held stall after which the queue must be full
    localparam int FULL_AGE   = 40;

    logic                           clk;
    logic                           rst;
    logic                           redirect_valid;
    frontend_pkg::addr_t            redirect_pc;
    logic                           bus_req_valid;
    frontend_pkg::addr_t            bus_req_addr;
    logic                           bus_resp_valid;
    logic [63:0]                    bus_resp_data;
    logic [1:0]                     inst_valid;
    frontend_pkg::addr_t      [1:0] inst_pc;
    frontend_pkg::inst_word_t [1:0] inst_word;
    frontend_pkg::reg_idx_t   [1:0] src0_reg;
    frontend_pkg::reg_idx_t   [1:0] src1_reg;
    frontend_pkg::reg_idx_t   [1:0] dst_reg;
    logic [1:0]                     issue_num;
    logic                           backend_stall;

    // records from the stimulus file
    logic [31:0] img_addr [$];
    logic [31:0] img_word [$];
    int          redir_cyc [$];
    logic [31:0] redir_pc [$];
    int          hold_start [$];
    int          hold_len [$];
    int          delay_max;

    // bus slave and reference model
    logic        pend;
    logic [31:0] pend_addr;
    int          pend_wait;
    logic [31:0] exp_req;
    logic [31:0] exp_pc;
    int          checks;
    int          errors;
    int          issued;

    tb_clock u_clock (.clk_o (clk));

    frontend u_frontend (
        .clk              (clk),
        .rst_i            (rst),
        .redirect_valid_i (redirect_valid),
        .redirect_pc_i    (redirect_pc),
        .bus_req_valid_o  (bus_req_valid),
        .bus_req_addr_o   (bus_req_addr),
        .bus_resp_valid_i (bus_resp_valid),
        .bus_resp_data_i  (bus_resp_data),
        .inst_valid_o     (inst_valid),
        .inst_pc_o        (inst_pc),
        .inst_word_o      (inst_word),
        .src0_reg_o       (src0_reg),
        .src1_reg_o       (src1_reg),
        .dst_reg_o        (dst_reg),
        .issue_num_i      (issue_num),
        .backend_stall_i  (backend_stall)
    );

    function automatic logic [31:0] word_at(input logic [31:0] a);
        logic [31:0] w;
        int          k;
        // words not in the image follow a fill built from the address
        w = {a[7:2], a[31:8], a[1:0]};
        for (k = 0; k < img_addr.size(); k++) begin
            if (img_addr[k] == a) begin
                w = img_word[k];
            end
        end
        return w;
    endfunction

    function automatic int hold_age(input int cyc);
        int k;
        int age;
        age = -1;
        for (k = 0; k < hold_start.size(); k++) begin
            if (cyc >= hold_start[k] && cyc < hold_start[k] + hold_len[k]) begin
                age = cyc - hold_start[k];
            end
        end
        return age;
    endfunction

    task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] got);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("MISMATCH %s expected %h got %h at %0t", name, exp, got, $time);
        end
    endtask

    task automatic check_slot(input int i);
        logic [31:0] w;
        logic [4:0]  s0;
        logic [4:0]  s1;
        logic [4:0]  d;
        w  = word_at(exp_pc);
        s0 = 5'd0;
        s1 = 5'd0;
        d  = 5'd0;
        // i-type and unknown opcodes use no registers
        case (w[31:26])
            frontend_pkg::OPC_RW: begin
                s1 = w[9:5];
                d  = w[4:0];
            end
            frontend_pkg::OPC_RRW: begin
                s0 = w[14:10];
                s1 = w[9:5];
                d  = w[4:0];
            end
            frontend_pkg::OPC_RR: begin
                s0 = w[4:0];
                s1 = w[9:5];
            end
            frontend_pkg::OPC_BL: begin
                d = 5'd1;
            end
            default: begin
            end
        endcase
        compare("inst_pc_o", exp_pc, inst_pc[i]);
        compare("inst_word_o", w, inst_word[i]);
        compare("src0_reg_o", s0, src0_reg[i]);
        compare("src1_reg_o", s1, src1_reg[i]);
        compare("dst_reg_o", d, dst_reg[i]);
        exp_pc = exp_pc + 32'd4;
        issued++;
    endtask

    // one request outstanding at a time
    task automatic bus_step();
        bus_resp_valid = 1'b0;
        if (pend) begin
            if (pend_wait <= 1) begin
                bus_resp_valid = 1'b1;
                bus_resp_data  = {word_at(pend_addr + 32'd4), word_at(pend_addr)};
                pend           = 1'b0;
            end else begin
                pend_wait--;
            end
        end
        if (bus_req_valid) begin
            if (pend) begin
                errors++;
                $display("bus request at %0t while another one is outstanding", $time);
            end
            // pairs follow each other from the last redirect target
            compare("bus_req_addr_o", exp_req, bus_req_addr);
            exp_req   = exp_req + 32'd8;
            pend      = 1'b1;
            pend_addr = bus_req_addr;
            pend_wait = 1 + ($urandom % delay_max);
        end
    endtask

    task automatic read_stim();
        int               fd;
        int               code;
        int               c;
        logic [63:0]      tag;
        logic [8*200-1:0] rest;
        logic [31:0]      a;
        logic [31:0]      w;
        fd = $fopen("tests/frontend_stim.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("cannot open the stimulus file tests/frontend_stim.txt");
            return;
        end
        code = $fscanf(fd, "%s", tag);
        while (code == 1) begin
            case (tag)
                "#": code = $fgets(rest, fd);
                "M": begin
                    code = $fscanf(fd, "%h %h", a, w);
                    img_addr.push_back(a);
                    img_word.push_back(w);
                end
                "R": begin
                    code = $fscanf(fd, "%d %h", c, a);
                    redir_cyc.push_back(c);
                    redir_pc.push_back(a);
                end
                "S": begin
                    code = $fscanf(fd, "%d %d", c, w);
                    hold_start.push_back(c);
                    hold_len.push_back(w);
                end
                "D": code = $fscanf(fd, "%d", delay_max);
                default: begin
                    errors++;
                    $display("unknown record in the stimulus file");
                end
            endcase
            code = $fscanf(fd, "%s", tag);
        end
        $fclose(fd);
    endtask

    initial begin
        int   seed;
        int   cyc;
        int   age;
        int   idle;
        int   nv;
        int   k;
        int   redir_idx;
        logic flush_chk;
        logic abort;
        rst            = 1'b1;
        redirect_valid = 1'b0;
        redirect_pc    = '0;
        bus_resp_valid = 1'b0;
        bus_resp_data  = '0;
        issue_num      = 2'd0;
        backend_stall  = 1'b0;
        pend           = 1'b0;
        pend_addr      = '0;
        pend_wait      = 0;
        checks         = 0;
        errors         = 0;
        issued         = 0;
        delay_max      = 4;
        exp_req        = frontend_pkg::RESET_PC;
        exp_pc         = frontend_pkg::RESET_PC;
        seed           = 32'h2c8f;
        void'($urandom(seed));
        read_stim();

        repeat (10) begin
            @(negedge clk);
            compare("bus_req_valid_o", 32'd0, bus_req_valid);
            compare("inst_valid_o", 32'd0, inst_valid);
        end
        rst       = 1'b0;
        idle      = 0;
        redir_idx = 0;
        flush_chk = 1'b1;
        abort     = 1'b0;

        for (cyc = 0; cyc < RUN_CYCLES && !abort; cyc++) begin
            @(negedge clk);
            // empty queue right after reset or a redirect
            if (flush_chk) begin
                compare("inst_valid_o", 32'd0, inst_valid);
                flush_chk = 1'b0;
            end
            if (inst_valid == 2'b10) begin
                errors++;
                $display("MISMATCH inst_valid_o expected 01 or 11 got %h", inst_valid);
            end
            age = hold_age(cyc);
            if (age > FULL_AGE) begin
                compare("inst_valid_o", 32'h3, inst_valid);
                if (bus_req_valid) begin
                    errors++;
                    $display("bus request at %0t although the queue is full", $time);
                end
            end
            bus_step();
            nv             = inst_valid[0] + inst_valid[1];
            issue_num      = 2'($urandom % (nv + 1));
            backend_stall  = (age >= 0) || ($urandom % 4 == 0);
            redirect_valid = 1'b0;
            if (redir_idx < redir_cyc.size() && cyc == redir_cyc[redir_idx]) begin
                redirect_valid = 1'b1;
                redirect_pc    = redir_pc[redir_idx];
                issue_num      = 2'd0;
                exp_pc         = redir_pc[redir_idx];
                exp_req        = {redir_pc[redir_idx][31:3], 3'b000};
                redir_idx++;
                flush_chk      = 1'b1;
                idle           = 0;
            end else if (!backend_stall && issue_num != 2'd0) begin
                for (k = 0; k < issue_num; k++) begin
                    check_slot(k);
                end
                idle = 0;
            end else if (age >= 0) begin
                idle = 0;
            end else begin
                idle++;
                if (idle > IDLE_LIMIT) begin
                    errors++;
                    $display("timeout, no instruction issued for %0d cycles", IDLE_LIMIT);
                    abort = 1'b1;
                end
            end
        end

        if (issued < 100) begin
            errors++;
            $display("only %0d instructions were issued", issued);
        end
        $display("checks %0d, errors %0d, issued %0d", checks, errors, issued);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

//--- tests/tb_clock.sv
module tb_clock (
    output logic clk_o
);
    timeunit 1ns;
    timeprecision 100ps;

    // 100 ns period
    initial begin
        clk_o = 1'b0;
        forever begin
            #50 clk_o = ~clk_o;
        end
    end

endmodule

//--- hw/frontend.sv
module frontend (
    input  logic                           clk,
    input  logic                           rst_i,

    // redirect from the back end
    input  logic                           redirect_valid_i,
    input  frontend_pkg::addr_t            redirect_pc_i,

    // instruction bus
    output logic                           bus_req_valid_o,
    output frontend_pkg::addr_t            bus_req_addr_o,
    input  logic                           bus_resp_valid_i,
    input  logic [63:0]                    bus_resp_data_i,

    // issue side
    output logic [1:0]                     inst_valid_o,
    output frontend_pkg::addr_t      [1:0] inst_pc_o,
    output frontend_pkg::inst_word_t [1:0] inst_word_o,
    output frontend_pkg::reg_idx_t   [1:0] src0_reg_o,
    output frontend_pkg::reg_idx_t   [1:0] src1_reg_o,
    output frontend_pkg::reg_idx_t   [1:0] dst_reg_o,
    input  logic [1:0]                     issue_num_i,
    input  logic                           backend_stall_i
);

    frontend_pkg::addr_t            pair_pc;
    logic [1:0]                     slot_mask;
    logic                           advance;
    logic [1:0]                     read_num;
    frontend_pkg::fifo_data_t [1:0] q_data;

    fetch_if fq ();

    pc_gen u_pc_gen (
        .clk              (clk),
        .rst_i            (rst_i),
        .redirect_valid_i (redirect_valid_i),
        .redirect_pc_i    (redirect_pc_i),
        .advance_i        (advance),
        .pair_pc_o        (pair_pc),
        .slot_mask_o      (slot_mask)
    );

    fetch_unit u_fetch_unit (
        .clk              (clk),
        .rst_i            (rst_i),
        .redirect_valid_i (redirect_valid_i),
        .pair_pc_i        (pair_pc),
        .slot_mask_i      (slot_mask),
        .advance_o        (advance),
        .bus_req_valid_o  (bus_req_valid_o),
        .bus_req_addr_o   (bus_req_addr_o),
        .bus_resp_valid_i (bus_resp_valid_i),
        .bus_resp_data_i  (bus_resp_data_i),
        .fq               (fq.fetch)
    );

    // a stalled back end takes nothing
    assign read_num = backend_stall_i ? 2'd0 : issue_num_i;

    multi_channel_fifo #(
        .DATA_WIDTH ($bits(frontend_pkg::fifo_data_t)),
        .DEPTH      (frontend_pkg::FIFO_DEPTH)
    ) u_inst_fifo (
        .clk          (clk),
        .rst_i        (rst_i),
        .flush_i      (redirect_valid_i),
        .fq           (fq.queue),
        .read_valid_o (inst_valid_o),
        .read_num_i   (read_num),
        .read_data_o  (q_data)
    );

    for (genvar i = 0; i < 2; i++) begin : g_slot
        assign inst_pc_o[i]   = q_data[i][63:32];
        assign inst_word_o[i] = q_data[i][31:0];

        inst_decoder u_decoder (
            .inst_i     (q_data[i][31:0]),
            .src0_reg_o (src0_reg_o[i]),
            .src1_reg_o (src1_reg_o[i]),
            .dst_reg_o  (dst_reg_o[i])
        );
    end

endmodule

//--- hw/inst_decoder.sv
module inst_decoder (
    input  frontend_pkg::inst_word_t inst_i,
    output frontend_pkg::reg_idx_t   src0_reg_o,
    output frontend_pkg::reg_idx_t   src1_reg_o,
    output frontend_pkg::reg_idx_t   dst_reg_o
);

    frontend_pkg::opcode_t  opcode;
    frontend_pkg::reg_idx_t rd;
    frontend_pkg::reg_idx_t rj;
    frontend_pkg::reg_idx_t rk;

    assign opcode = inst_i[frontend_pkg::OPC_LSB +: frontend_pkg::OPC_W];
    assign rd     = inst_i[frontend_pkg::RD_LSB +: frontend_pkg::REG_IDX_W];
    assign rj     = inst_i[frontend_pkg::RJ_LSB +: frontend_pkg::REG_IDX_W];
    assign rk     = inst_i[frontend_pkg::RK_LSB +: frontend_pkg::REG_IDX_W];

    always_comb begin
        case (opcode)
            frontend_pkg::OPC_I: begin
                src0_reg_o = '0;
                src1_reg_o = '0;
                dst_reg_o  = '0;
            end
            frontend_pkg::OPC_RW: begin
                src0_reg_o = '0;
                src1_reg_o = rj;
                dst_reg_o  = rd;
            end
            frontend_pkg::OPC_RRW: begin
                src0_reg_o = rk;
                src1_reg_o = rj;
                dst_reg_o  = rd;
            end
            frontend_pkg::OPC_RR: begin
                // rd is a source here, e.g. stores and branches
                src0_reg_o = rd;
                src1_reg_o = rj;
                dst_reg_o  = '0;
            end
            frontend_pkg::OPC_BL: begin
                src0_reg_o = '0;
                src1_reg_o = '0;
                dst_reg_o  = frontend_pkg::LINK_REG;
            end
            default: begin
                // unknown opcode uses no registers
                src0_reg_o = '0;
                src1_reg_o = '0;
                dst_reg_o  = '0;
            end
        endcase
    end

endmodule

//--- hw/multi_channel_fifo.sv
module multi_channel_fifo #(
    parameter int DATA_WIDTH = 64,
    parameter int DEPTH      = 8
) (
    input  logic                       clk,
    input  logic                       rst_i,
    input  logic                       flush_i,
    fetch_if.queue                     fq,
    output logic [1:0]                 read_valid_o,
    input  logic [1:0]                 read_num_i,
    output logic [1:0][DATA_WIDTH-1:0] read_data_o
);

    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    logic [DATA_WIDTH-1:0] mem [DEPTH];
    logic [PTR_W-1:0]      wr_ptr_q;
    logic [PTR_W-1:0]      rd_ptr_q;
    logic [CNT_W-1:0]      count_q;
    logic [1:0]            write_num;
    logic [DATA_WIDTH-1:0] slot_entry [2];
    logic [DATA_WIDTH-1:0] first_entry;

    // entries carry their own pc
    assign slot_entry[0] = {fq.pair_pc, fq.inst[0]};
    assign slot_entry[1] = {fq.pair_pc + 32'd4, fq.inst[1]};

    assign write_num = {fq.valid[0] & fq.valid[1], fq.valid[0] ^ fq.valid[1]};

    // compaction, a lone slot 1 goes to the first free entry
    assign first_entry = fq.valid[0] ? slot_entry[0] : slot_entry[1];

    assign fq.ready = (count_q <= CNT_W'(DEPTH - 2));

    always_comb begin
        if (count_q >= CNT_W'(2)) begin
            read_valid_o = 2'b11;
        end else if (count_q == CNT_W'(1)) begin
            read_valid_o = 2'b01;
        end else begin
            read_valid_o = 2'b00;
        end
    end

    assign read_data_o[0] = mem[rd_ptr_q];
    assign read_data_o[1] = mem[rd_ptr_q + PTR_W'(1)];

    always_ff @(posedge clk) begin
        if (write_num != 2'd0) begin
            mem[wr_ptr_q] <= first_entry;
        end
        if (write_num == 2'd2) begin
            mem[wr_ptr_q + PTR_W'(1)] <= slot_entry[1];
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i || flush_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            wr_ptr_q <= wr_ptr_q + PTR_W'(write_num);
            rd_ptr_q <= rd_ptr_q + PTR_W'(read_num_i);
            count_q  <= count_q + CNT_W'(write_num) - CNT_W'(read_num_i);
        end
    end

endmodule

//--- hw/fetch_unit.sv
module fetch_unit (
    input  logic                clk,
    input  logic                rst_i,
    input  logic                redirect_valid_i,
    input  frontend_pkg::addr_t pair_pc_i,
    input  logic [1:0]          slot_mask_i,
    output logic                advance_o,
    output logic                bus_req_valid_o,
    output frontend_pkg::addr_t bus_req_addr_o,
    input  logic                bus_resp_valid_i,
    input  logic [63:0]         bus_resp_data_i,
    fetch_if.fetch              fq
);

    frontend_pkg::fetch_state_e state_q;
    frontend_pkg::fetch_state_e state_d;
    logic                       req_q;
    frontend_pkg::addr_t        req_pc_q;
    logic [1:0]                 req_mask_q;
    logic                       take_pc;
    logic                       resp_ok;

    // a request needs room for a whole pair in the queue
    assign take_pc   = (state_q == frontend_pkg::IDLE) && fq.ready && !redirect_valid_i;
    assign advance_o = take_pc;

    // redirect in the response cycle kills the write
    assign resp_ok = (state_q == frontend_pkg::WAIT_RESP) && bus_resp_valid_i &&
                     !redirect_valid_i;

    always_comb begin
        state_d = state_q;
        case (state_q)
            frontend_pkg::IDLE: begin
                if (take_pc) begin
                    state_d = frontend_pkg::WAIT_RESP;
                end
            end
            frontend_pkg::WAIT_RESP: begin
                if (bus_resp_valid_i) begin
                    state_d = frontend_pkg::IDLE;
                end else if (redirect_valid_i) begin
                    // response still in flight, throw it away
                    state_d = frontend_pkg::DROP_RESP;
                end
            end
            frontend_pkg::DROP_RESP: begin
                if (bus_resp_valid_i) begin
                    state_d = frontend_pkg::IDLE;
                end
            end
            default: begin
                state_d = frontend_pkg::IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            state_q <= frontend_pkg::IDLE;
            req_q   <= 1'b0;
        end else begin
            state_q <= state_d;
            // one-cycle request pulse
            req_q   <= take_pc;
        end
    end

    // pc and mask of the outstanding request
    always_ff @(posedge clk) begin
        if (take_pc) begin
            req_pc_q   <= pair_pc_i;
            req_mask_q <= slot_mask_i;
        end
    end

    assign bus_req_valid_o = req_q;
    assign bus_req_addr_o  = req_pc_q;

    assign fq.valid   = resp_ok ? req_mask_q : 2'b00;
    assign fq.pair_pc = req_pc_q;
    assign fq.inst[0] = bus_resp_data_i[31:0];
    assign fq.inst[1] = bus_resp_data_i[63:32];

endmodule

//--- hw/pc_gen.sv
module pc_gen (
    input  logic                clk,
    input  logic                rst_i,
    input  logic                redirect_valid_i,
    input  frontend_pkg::addr_t redirect_pc_i,
    input  logic                advance_i,
    output frontend_pkg::addr_t pair_pc_o,
    output logic [1:0]          slot_mask_o
);

    frontend_pkg::addr_t pair_pc_q;
    logic [1:0]          mask_q;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            pair_pc_q <= frontend_pkg::RESET_PC;
            mask_q    <= 2'b11;
        end else if (redirect_valid_i) begin
            // align down to the pair, skip slot 0 for an odd-word target
            pair_pc_q <= {redirect_pc_i[31:3], 3'b000};
            mask_q    <= {1'b1, ~redirect_pc_i[2]};
        end else if (advance_i) begin
            pair_pc_q <= pair_pc_q + 32'd8;
            // later pairs are always fetched whole
            mask_q    <= 2'b11;
        end
    end

    assign pair_pc_o   = pair_pc_q;
    assign slot_mask_o = mask_q;

endmodule

//--- hw/fetch_if.sv
interface fetch_if;

    // one enable per slot, slot 0 is the lower word of the pair
    logic [1:0]                     valid;
    frontend_pkg::addr_t            pair_pc;
    frontend_pkg::inst_word_t [1:0] inst;
    // at least two free entries
    logic                           ready;

    modport fetch (
        output valid,
        output pair_pc,
        output inst,
        input  ready
    );

    modport queue (
        input  valid,
        input  pair_pc,
        input  inst,
        output ready
    );

endinterface

//--- hw/frontend_pkg.sv
package frontend_pkg;

    // field widths
    localparam int ADDR_W    = 32;
    localparam int INST_W    = 32;
    localparam int REG_IDX_W = 5;
    localparam int OPC_W     = 6;

    typedef logic [ADDR_W-1:0]    addr_t;
    typedef logic [INST_W-1:0]    inst_word_t;
    typedef logic [REG_IDX_W-1:0] reg_idx_t;
    typedef logic [OPC_W-1:0]     opcode_t;

    // queue entry, pc in the upper half and instruction word below
    typedef logic [ADDR_W+INST_W-1:0] fifo_data_t;

    typedef enum logic [1:0] {
        IDLE,
        WAIT_RESP,
        DROP_RESP
    } fetch_state_e;

    // first pair fetched after reset
    localparam addr_t RESET_PC = 32'h1c00_0000;

    // instruction queue entries
    localparam int FIFO_DEPTH = 8;

    // bit positions of the register and opcode fields
    localparam int RD_LSB  = 0;
    localparam int RJ_LSB  = 5;
    localparam int RK_LSB  = 10;
    localparam int OPC_LSB = 26;

    // opcodes selecting the register-type class
    localparam opcode_t OPC_I   = 6'h01;
    localparam opcode_t OPC_RW  = 6'h02;
    localparam opcode_t OPC_RRW = 6'h03;
    localparam opcode_t OPC_RR  = 6'h04;
    localparam opcode_t OPC_BL  = 6'h15;

    // bl writes the return address here
    localparam reg_idx_t LINK_REG = 5'd1;

endpackage
